//--- jag_abus.f
+incdir+.
jag_abus_pkg.sv
memcon_regs.sv
addr_decode.sv
dram_addr_mux.sv
row_page_tracker.sv
cycle_latch.sv
jag_abus_top.sv
jag_abus_asserts.sv
jag_abus_tb.sv

//--- jag_abus_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the address bus section
// with reference rules and test report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module jag_abus_tb;

	// Defined MEMCON1 bits are 0..7 and 11..14
	localparam logic [15:0] MC1_FIELDS = 16'h78ff;
	localparam int WAIT_LIMIT = 8;

	logic sys_clk;
	logic resetl;
	jag_abus_pkg::addr_t addr;
	logic mreq;
	logic ack;
	logic mux;
	logic newrow;
	logic resrow;
	logic [`JAG_DR_W-1:0] din;
	logic memc1w;
	logic memc2w;
	logic memc1r;
	logic memc2r;
	logic [`JAG_DR_W-1:0] dr_out;
	logic dr_oe;
	jag_abus_pkg::memcon1_t cfg1;
	logic fdram;
	logic fintdev;
	logic fextdev;
	logic from;
	logic [1:0] mw;
	logic [3:0] bs;
	logic dram;
	logic intdev;
	logic [`JAG_MA_W-1:0] ma;
	logic match;

	integer seed;
	int errors;
	int checks;
	int tests;
	int errs_at_start;
	// Register state as the bus should see it
	logic [15:0] cur_mc1;
	logic [7:0] cur_mc2;
	logic mset_model;

	jag_abus_top DUT (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// Inputs move 1 ns after the edge
	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic check_equal(
		input string name,
		input logic [31:0] got,
		input logic [31:0] want
	);
		checks++;
		assert (got === want) else begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	// 0 ROM with device window, 1 other ROM, 2 bank1, 3 bank0
	function automatic int region_of(input logic [23:0] a, input logic romhi, input logic set);
		if (!set) begin
			return 0;
		end
		if (!romhi) begin
			case (a[23:21])
				3'b000: return 0;
				3'b001, 3'b010, 3'b011: return 1;
				3'b100, 3'b101: return 2;
				default: return 3;
			endcase
		end
		// ROM at the top, map mirrored
		case (a[23:21])
			3'b111: return 0;
			3'b110, 3'b101, 3'b100: return 1;
			3'b011, 3'b010: return 2;
			default: return 3;
		endcase
	endfunction

	function automatic logic [3:0] bs_rule(input int rgn, input logic win);
		logic rom;
		rom = ((rgn == 0) && !win) || (rgn == 1);
		return {rgn == 3, rgn == 2, rgn == 1, rom};
	endfunction

	function automatic logic [1:0] mw_rule(input int rgn, input logic [23:0] a);
		if (rgn == 2) begin
			return cur_mc2[7:6];
		end
		if (rgn == 3) begin
			return cur_mc2[3:2];
		end
		if ((rgn == 0) && (a[20:17] == `JAG_DEV_WIN)) begin
			// Everything else in the window is a 16-bit device
			return (a[20:15] == `JAG_DEV32) ? 2'd2 : 2'd1;
		end
		return cur_mc1[2:1];
	endfunction

	// geo holds {dwid, cols} of one bank
	function automatic logic [10:0] row_rule(input logic [3:0] geo, input logic [23:0] a);
		int sh;
		// Largest shift is 14, leaving ten row bits
		sh = `JAG_ROW_LSB + int'(geo[1:0]) + int'(geo[3:2]);
		return 11'(a >> sh);
	endfunction

	function automatic logic [10:0] col_rule(input logic [3:0] geo, input logic [23:0] a);
		return 11'(a >> geo[3:2]);
	endfunction

	task automatic write_config(input logic second, input logic [15:0] val);
		din = val;
		memc1w = !second;
		memc2w = second;
		next_cycle();
		memc1w = 1'b0;
		memc2w = 1'b0;
		if (second) begin
			cur_mc2 = val[7:0];
		end else begin
			cur_mc1 = val & MC1_FIELDS;
			mset_model = 1'b1;
		end
	endtask

	task automatic read_register(input logic r1, input logic r2, input logic [15:0] want);
		int n;
		memc1r = r1;
		memc2r = r2;
		n = 0;
		#1;
		// Wait for the bus to drive, bounded
		while (!dr_oe && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!dr_oe) begin
			$display("Readback enable never rose during a register read");
			errors++;
		end
		check_equal("dr_out", dr_out, want);
		next_cycle();
		memc1r = 1'b0;
		memc2r = 1'b0;
	endtask

	// Early decode in the same cycle, latched selects one cycle later
	task automatic decode_vector(input jag_abus_pkg::addr_t a);
		int rgn;
		logic [3:0] want_bs;
		rgn = region_of(a, cur_mc1[0], mset_model);
		want_bs = bs_rule(rgn, a[20:17] == `JAG_DEV_WIN);
		addr = a;
		mreq = 1'b1;
		ack = 1'b1;
		#1;
		check_equal("from", from, want_bs[0]);
		check_equal("fdram", fdram, want_bs[3] | want_bs[2]);
		check_equal("fintdev", fintdev, (rgn == 0) && (a[20:16] == `JAG_DEV_INT));
		check_equal("fextdev", fextdev, (rgn == 0) && (a[20:16] == `JAG_DEV_EXT));
		check_equal("mw", mw, mw_rule(rgn, a));
		next_cycle();
		check_equal("bs", bs, want_bs);
		check_equal("dram", dram, want_bs[3] | want_bs[2]);
		check_equal("intdev", intdev, (rgn == 0) && (a[20:16] == `JAG_DEV_INT));
		ack = 1'b0;
	endtask

	task automatic ma_vector(input jag_abus_pkg::addr_t a, input logic m);
		logic [3:0] geo;
		logic [10:0] want;
		geo = (region_of(a, cur_mc1[0], mset_model) == 2) ? cur_mc2[7:4] : cur_mc2[3:0];
		want = m ? row_rule(geo, a) : col_rule(geo, a);
		addr = a;
		mreq = 1'b1;
		ack = 1'b1;
		mux = m;
		next_cycle();
		check_equal("ma", ma, want);
		ack = 1'b0;
		mux = 1'b0;
	endtask

	// Open a row in one bank, then hit, miss and clear it
	task automatic page_check(input logic b);
		jag_abus_pkg::addr_t a;
		logic [3:0] geo;
		int sh;
		a = `JAG_ADDR_W'($random(seed));
		a[23:21] = b ? 3'b100 : 3'b110;
		geo = b ? cur_mc2[7:4] : cur_mc2[3:0];
		sh = `JAG_ROW_LSB + int'(geo[1:0]) + int'(geo[3:2]);
		addr = a;
		mreq = 1'b1;
		ack = 1'b1;
		next_cycle();
		ack = 1'b0;
		newrow = 1'b1;
		next_cycle();
		newrow = 1'b0;
		#1;
		check_equal("match", match, 1);
		next_cycle();
		// Lowest row bit flipped
		addr = a ^ (24'd1 << sh);
		#1;
		check_equal("match", match, 0);
		next_cycle();
		addr = a;
		resrow = 1'b1;
		next_cycle();
		resrow = 1'b0;
		for (int i = 0; i < 4; i++) begin
			#1;
			check_equal("match", match, 0);
			next_cycle();
			addr = {a[23:21], 21'($random(seed))};
		end
	endtask

	initial begin
		jag_abus_pkg::addr_t a;
		seed = 46392;
		errors = 0;
		checks = 0;
		tests = 0;
		errs_at_start = 0;
		cur_mc1 = '0;
		cur_mc2 = '0;
		mset_model = 1'b0;
		resetl = 1'b0;
		addr = '0;
		mreq = 1'b0;
		ack = 1'b0;
		mux = 1'b0;
		newrow = 1'b0;
		resrow = 1'b0;
		din = '0;
		memc1w = 1'b0;
		memc2w = 1'b0;
		memc1r = 1'b0;
		memc2r = 1'b0;
		repeat (8) @(posedge sys_clk);
		#1;
		resetl = 1'b1;

		// Boot map, every other address in the device window
		for (int i = 0; i < 16; i++) begin
			a = `JAG_ADDR_W'($random(seed));
			if (i % 2 == 1) begin
				a[20:17] = `JAG_DEV_WIN;
			end
			decode_vector(a);
		end
		report_test("boot_map");

		write_config(1'b0, 16'($random(seed)));
		read_register(1'b1, 1'b0, cur_mc1);
		check_equal("cfg1", cfg1, cur_mc1);
		write_config(1'b1, 16'($random(seed)));
		read_register(1'b0, 1'b1, {8'h00, cur_mc2});
		read_register(1'b1, 1'b1, cur_mc1 | {8'h00, cur_mc2});
		report_test("readback");

		// ROM low, then ROM high
		write_config(1'b0, 16'($random(seed)) & 16'hfffe);
		for (int i = 0; i < 16; i++) begin
			decode_vector(`JAG_ADDR_W'($random(seed)));
		end
		write_config(1'b0, 16'($random(seed)) | 16'h0001);
		for (int i = 0; i < 16; i++) begin
			decode_vector(`JAG_ADDR_W'($random(seed)));
		end
		report_test("region_map");

		write_config(1'b0, 16'($random(seed)) & 16'hfffe);
		for (int i = 0; i < 12; i++) begin
			a = `JAG_ADDR_W'($random(seed));
			a[23:17] = {3'b000, `JAG_DEV_WIN};
			decode_vector(a);
		end
		report_test("device_window");

		// Fresh geometry every four addresses
		for (int i = 0; i < 16; i++) begin
			if (i % 4 == 0) begin
				write_config(1'b1, 16'($random(seed)));
			end
			ma_vector(`JAG_ADDR_W'($random(seed)), i[0]);
		end
		report_test("dram_address");

		page_check(1'b0);
		page_check(1'b1);
		report_test("page_match");

		// Bound checker failures
		errors += DUT.u_asserts.fails;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- jag_abus_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on reset state, readback
// enable, ma timing and select hold
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module jag_abus_asserts (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic ack,
	input wire logic memc1r,
	input wire logic memc2r,
	input wire logic dr_oe,
	input wire logic [`JAG_MA_W-1:0] mad,
	input wire logic [`JAG_MA_W-1:0] ma,
	input wire logic [3:0] bs,
	input wire logic dram,
	input wire logic intdev,
	input wire logic match
);

	// Failed assertion count
	int fails = 0;

	// Reset leaves every latched output low
	reset_quiet: assert property (@(posedge sys_clk)
		!resetl |=> (bs == 4'h0 && !dram && !intdev && ma == '0 && !match))
		else begin
			$error("latched outputs not zero after a reset cycle");
			fails++;
		end

	// Bus drives only for a register read
	oe_follows_read: assert property (@(posedge sys_clk)
		dr_oe == (memc1r || memc2r))
		else begin
			$error("dr_oe differs from the read strobes");
			fails++;
		end

	// ma trails mad by one cycle
	ma_trails_mad: assert property (@(posedge sys_clk) disable iff (!resetl)
		$past(resetl) |-> (ma == $past(mad)))
		else begin
			$error("ma is not the previous cycle's mad");
			fails++;
		end

	// Latched cycle holds without ack
	sel_holds: assert property (@(posedge sys_clk) disable iff (!resetl)
		!ack |=> ($stable(bs) && $stable(dram) && $stable(intdev)))
		else begin
			$error("latched selects changed while ack was low");
			fails++;
		end

endmodule

bind jag_abus_top jag_abus_asserts u_asserts (
	.sys_clk(sys_clk),
	.resetl(resetl),
	.ack(ack),
	.memc1r(memc1r),
	.memc2r(memc2r),
	.dr_oe(dr_oe),
	.mad(mad),
	.ma(ma),
	.bs(bs),
	.dram(dram),
	.intdev(intdev),
	.match(match)
);

`default_nettype wire

//--- jag_abus_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address bus section top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module jag_abus_top (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire jag_abus_pkg::addr_t addr,
	input wire logic mreq,
	input wire logic ack,
	input wire logic mux,
	input wire logic newrow,
	input wire logic resrow,
	input wire logic [`JAG_DR_W-1:0] din,
	input wire logic memc1w,
	input wire logic memc2w,
	input wire logic memc1r,
	input wire logic memc2r,
	output logic [`JAG_DR_W-1:0] dr_out,
	output logic dr_oe,
	output jag_abus_pkg::memcon1_t cfg1,
	output logic fdram,
	output logic fintdev,
	output logic fextdev,
	output logic from,
	output logic [1:0] mw,
	output logic [3:0] bs,
	output logic dram,
	output logic intdev,
	output logic [`JAG_MA_W-1:0] ma,
	output logic match
);

	jag_abus_pkg::memcon2_t mc2;
	jag_abus_pkg::bank_geom_t geom0;
	jag_abus_pkg::bank_geom_t geom1;
	jag_abus_pkg::mem_sel_t sel_now;
	jag_abus_pkg::mem_sel_t sel_q;
	logic mset;
	logic bank1_cur;
	logic [`JAG_MA_W-1:0] row0;
	logic [`JAG_MA_W-1:0] row1;
	logic [`JAG_MA_W-1:0] mad;
	logic hit0;
	logic hit1;
	logic load0;
	logic load1;

	// Per-bank geometry from MEMCON2
	assign geom0 = '{cols: mc2.cols0, dwid: mc2.dwid0};
	assign geom1 = '{cols: mc2.cols1, dwid: mc2.dwid1};

	// Early decode straight out
	assign fdram = sel_now.bank0 | sel_now.bank1;
	assign fintdev = sel_now.fintdev;
	assign fextdev = sel_now.fextdev;
	assign from = sel_now.rom;
	assign mw = sel_now.mw;

	// Row loads follow the latched bank
	assign load0 = newrow & sel_q.bank0;
	assign load1 = newrow & sel_q.bank1;

	memcon_regs u_regs (
		.sys_clk(sys_clk), .resetl(resetl), .din(din),
		.memc1w(memc1w), .memc2w(memc2w), .memc1r(memc1r), .memc2r(memc2r),
		.mc1(cfg1), .mc2(mc2), .mset(mset), .dr_out(dr_out), .dr_oe(dr_oe)
	);

	addr_decode u_decode (
		.addr(addr), .mreq(mreq), .mc1(cfg1), .mset(mset),
		.geom0(geom0), .geom1(geom1), .sel_now(sel_now)
	);

	dram_addr_mux u_mux (
		.addr(addr), .geom0(geom0), .geom1(geom1), .bank1_cur(bank1_cur),
		.mux(mux), .row0(row0), .row1(row1), .mad(mad)
	);

	row_page_tracker #(.BANK(0)) u_trk0 (
		.sys_clk(sys_clk), .resetl(resetl), .row(row0),
		.load(load0), .clear(resrow), .hit(hit0)
	);

	row_page_tracker #(.BANK(1)) u_trk1 (
		.sys_clk(sys_clk), .resetl(resetl), .row(row1),
		.load(load1), .clear(resrow), .hit(hit1)
	);

	cycle_latch u_latch (
		.sys_clk(sys_clk), .resetl(resetl), .ack(ack), .sel_now(sel_now),
		.mad(mad), .hit0(hit0), .hit1(hit1), .sel_q(sel_q),
		.bank1_cur(bank1_cur), .bs(bs), .dram(dram), .intdev(intdev),
		.ma(ma), .match(match)
	);

endmodule

`default_nettype wire

//--- cycle_latch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cycle select latch, ma register
// and page match
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module cycle_latch (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic ack,
	input wire jag_abus_pkg::mem_sel_t sel_now,
	input wire logic [`JAG_MA_W-1:0] mad,
	input wire logic hit0,
	input wire logic hit1,
	output jag_abus_pkg::mem_sel_t sel_q,
	output logic bank1_cur,
	output logic [3:0] bs,
	output logic dram,
	output logic intdev,
	output logic [`JAG_MA_W-1:0] ma,
	output logic match
);

	// Selects held between acks
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			sel_q <= '0;
			ma <= '0;
		end else begin
			if (ack) begin
				sel_q <= sel_now;
			end
			// DRAM address out is one cycle behind mad
			ma <= mad;
		end
	end

	// Current bank looks through the latch during ack
	assign bank1_cur = ack ? sel_now.bank1 : sel_q.bank1;

	assign bs = {sel_q.bank0, sel_q.bank1, sel_q.rom1, sel_q.rom};
	assign dram = sel_q.bank0 | sel_q.bank1;
	assign intdev = sel_q.fintdev;

	// Page hit only counts for the bank of the latched cycle
	assign match = (hit0 & sel_q.bank0) | (hit1 & sel_q.bank1);

endmodule

`default_nettype wire

//--- row_page_tracker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Open row tracker for one DRAM bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module row_page_tracker #(
	parameter int BANK = 0
) (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [`JAG_MA_W-1:0] row,
	input wire logic load,
	input wire logic clear,
	output logic hit
);

	logic [`JAG_MA_W-1:0] open_row;
	logic valid;

	// Row store
	always_ff @(posedge sys_clk) begin
		if (load) begin
			open_row <= row;
		end
	end

	// Load wins over clear
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (clear) begin
			valid <= 1'b0;
		end
	end

	assign hit = valid && (row == open_row);

endmodule

`default_nettype wire

//--- dram_addr_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DRAM row and column address mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module dram_addr_mux (
	input wire jag_abus_pkg::addr_t addr,
	input wire jag_abus_pkg::bank_geom_t geom0,
	input wire jag_abus_pkg::bank_geom_t geom1,
	input wire logic bank1_cur,
	input wire logic mux,
	output logic [`JAG_MA_W-1:0] row0,
	output logic [`JAG_MA_W-1:0] row1,
	output logic [`JAG_MA_W-1:0] mad
);

	jag_abus_pkg::bank_geom_t gsel;
	jag_abus_pkg::addr_t col_sh;

	// Row field sits above the column and byte lanes
	function automatic logic [`JAG_MA_W-1:0] row_of(
		input jag_abus_pkg::bank_geom_t g,
		input jag_abus_pkg::addr_t a
	);
		logic [2:0] cw;
		jag_abus_pkg::addr_t sh;
		cw = 3'(g.cols) + 3'(g.dwid);
		// Widest geometry leaves ten row bits under a zero
		sh = a >> (`JAG_ROW_LSB + cw);
		return sh[`JAG_MA_W-1:0];
	endfunction

	assign row0 = row_of(geom0, addr);
	assign row1 = row_of(geom1, addr);

	// Column drops the byte lanes of the selected bank
	assign gsel = bank1_cur ? geom1 : geom0;
	assign col_sh = addr >> gsel.dwid;

	// Row phase on mux high
	assign mad = mux ? (bank1_cur ? row1 : row0) : col_sh[`JAG_MA_W-1:0];

endmodule

`default_nettype wire

//--- addr_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decode into region selects
// and port width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module addr_decode (
	input wire jag_abus_pkg::addr_t addr,
	input wire logic mreq,
	input wire jag_abus_pkg::memcon1_t mc1,
	input wire logic mset,
	input wire jag_abus_pkg::bank_geom_t geom0,
	input wire jag_abus_pkg::bank_geom_t geom1,
	output jag_abus_pkg::mem_sel_t sel_now
);

	logic [2:0] hi;
	logic [2:0] hi_eff;
	logic dev_win;
	logic dev32;
	logic rgn0;
	logic rgn1;
	logic rgn_b1;
	logic rgn_b0;

	// romhi mirrors the map, so fold it onto the romlo table
	assign hi = addr[`JAG_ADDR_W-1 -: 3];
	assign hi_eff = mc1.romhi ? ~hi : hi;

	assign dev_win = addr[20:17] == `JAG_DEV_WIN;
	assign dev32 = addr[20:15] == `JAG_DEV32;

	// Boot map is one device-bearing ROM region
	assign rgn0 = !mset || (hi_eff == `JAG_RGN_DEV);
	assign rgn1 = mset && ((hi_eff == `JAG_RGN_ROM1) || (hi_eff[2:1] == 2'b01));
	assign rgn_b1 = mset && (hi_eff[2:1] == 2'b10);
	assign rgn_b0 = mset && (hi_eff[2:1] == 2'b11);

	always_comb begin
		sel_now = '0;
		// ROM excludes the device window
		sel_now.rom = mreq && ((rgn0 && !dev_win) || rgn1);
		sel_now.rom1 = mreq && rgn1;
		sel_now.fintdev = mreq && rgn0 && (addr[20:16] == `JAG_DEV_INT);
		sel_now.fextdev = mreq && rgn0 && (addr[20:16] == `JAG_DEV_EXT);
		sel_now.bank1 = mreq && rgn_b1;
		sel_now.bank0 = mreq && rgn_b0;

		// Port width, not gated by mreq
		if (rgn_b1) begin
			sel_now.mw = geom1.dwid;
		end else if (rgn_b0) begin
			sel_now.mw = geom0.dwid;
		end else if (rgn0 && dev_win) begin
			// Window holds only 16 and 32 bit devices
			if (dev32) begin
				sel_now.mw = 2'd2;
			end else begin
				sel_now.mw = 2'd1;
			end
		end else begin
			sel_now.mw = mc1.romwid;
		end
	end

endmodule

`default_nettype wire

//--- memcon_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEMCON1/MEMCON2 registers, memory-set
// flag and data bus readback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "jag_abus_params.svh"

module memcon_regs (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [`JAG_DR_W-1:0] din,
	input wire logic memc1w,
	input wire logic memc2w,
	input wire logic memc1r,
	input wire logic memc2r,
	output jag_abus_pkg::memcon1_t mc1,
	output jag_abus_pkg::memcon2_t mc2,
	output logic mset,
	output logic [`JAG_DR_W-1:0] dr_out,
	output logic dr_oe
);

	// Keeps bits 8..10 of MEMCON1 at zero
	localparam logic [14:0] MC1_MASK = 15'h78ff;

	logic [`JAG_DR_W-1:0] rd1;
	logic [`JAG_DR_W-1:0] rd2;

	// Writes land on the strobe edge
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mc1 <= '0;
			mc2 <= '0;
			mset <= 1'b0;
		end else begin
			if (memc1w) begin
				mc1 <= jag_abus_pkg::memcon1_t'(din[14:0] & MC1_MASK);
				// First MEMCON1 write ends the boot map
				mset <= 1'b1;
			end
			if (memc2w) begin
				mc2 <= jag_abus_pkg::memcon2_t'(din[7:0]);
			end
		end
	end

	// Zero-extended register images
	assign rd1 = `JAG_DR_W'(mc1);
	assign rd2 = `JAG_DR_W'(mc2);

	// Shared bus, both strobes together OR the images
	assign dr_out = ({`JAG_DR_W{memc1r}} & rd1) | ({`JAG_DR_W{memc2r}} & rd2);
	assign dr_oe = memc1r | memc2r;

endmodule

`default_nettype wire

//--- jag_abus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration, select and address types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "jag_abus_params.svh"

package jag_abus_pkg;

	// One CPU address
	typedef logic [`JAG_ADDR_W-1:0] addr_t;

	// MEMCON1 bits 0..14, bit 15 reads 0
	typedef struct packed {
		logic cpu32;
		logic nocpu;
		logic [1:0] iospd;
		// Bits 8..10 unused, always 0
		logic [2:0] rsvd;
		logic fastrom;
		logic [1:0] dspd;
		logic [1:0] romspd;
		logic [1:0] romwid;
		logic romhi;
	} memcon1_t;

	// MEMCON2 bits 0..7, geometry of both DRAM banks
	typedef struct packed {
		logic [1:0] dwid1;
		logic [1:0] cols1;
		logic [1:0] dwid0;
		logic [1:0] cols0;
	} memcon2_t;

	// Decoded selects for one bus cycle
	typedef struct packed {
		logic rom;
		// ROM outside the device-bearing region
		logic rom1;
		logic fintdev;
		logic fextdev;
		logic bank1;
		logic bank0;
		// 0 = 8, 1 = 16, 2 = 32, 3 = 64 bit
		logic [1:0] mw;
	} mem_sel_t;

	// One bank's column count and data width codes
	typedef struct packed {
		logic [1:0] cols;
		logic [1:0] dwid;
	} bank_geom_t;

endpackage

`default_nettype wire

//--- jag_abus_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address bus widths, region codes,
// device codes and port width codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef JAG_ABUS_PARAMS_SVH
`define JAG_ABUS_PARAMS_SVH

// Bus widths
`define JAG_ADDR_W 24
`define JAG_MA_W 11
`define JAG_DR_W 16

// Region codes on the top three address bits, romhi low
`define JAG_RGN_DEV 3'b000
`define JAG_RGN_ROM1 3'b001

// Device window on address bits 20..17
`define JAG_DEV_WIN 4'b1000

// Device codes on bits 20..16
`define JAG_DEV_INT 5'b10000
`define JAG_DEV_EXT 5'b10001

// Port width codes, _A and 32 compare on bits 20..15
`define JAG_DEV16_A 6'b100000
`define JAG_DEV16_B 5'b10001
`define JAG_DEV32 6'b100001

// DRAM row field starts here before the cols/dwid shift
`define JAG_ROW_LSB 8

`endif
